// File: include/timerUnit_defines.svh
`ifndef TIMERUNIT_DEFINES_SVH
`define TIMERUNIT_DEFINES_SVH

// ==============================
// Timer field widths
// ==============================

// Prescale register and prescale counter
`define TMR_PRE_W 8

// Count and period registers, host data path
`define TMR_CNT_W 16

// Host register address
`define TMR_ADDR_W 2

// Zero bits above TSR when it is read back
`define TMR_PRE_PAD (`TMR_CNT_W - `TMR_PRE_W)

`endif

// File: hw/timerPkg.sv
`default_nettype none
`include "timerUnit_defines.svh"

package timerPkg;

  // ==============================
  // Host register map
  // ==============================
  typedef enum logic [`TMR_ADDR_W-1:0]
  {
    REG_TSR,                              // Prescale
    REG_TCR,                              // Count
    REG_TPR,                              // Period
    REG_NONE                              // Unmapped, reads zero
  } regAddr_e;

  // ==============================
  // Stage messages
  // ==============================
  typedef struct packed
  {
    logic                  loadPre;       // Reload prescaler from TSR
    logic                  loadCnt;       // Reload count from TCR
    logic [`TMR_PRE_W-1:0] preVal;        // TSR
    logic [`TMR_CNT_W-1:0] cntVal;        // TCR
    logic [`TMR_CNT_W-1:0] period;        // TPR
  } cfgMsg_t;

  typedef struct packed
  {
    logic                  tick;          // One count step
    logic                  loadCnt;       // Count load, follows the prescale register
    logic [`TMR_CNT_W-1:0] cntVal;
    logic [`TMR_CNT_W-1:0] period;
  } tickMsg_t;

  typedef struct packed
  {
    logic expire;                         // Count wrapped through zero
  } expireMsg_t;

endpackage

`default_nettype wire

// File: hw/timerRegs.sv
`timescale 1ns/10ps
`default_nettype none
`include "timerUnit_defines.svh"

module timerRegs
(
  input  wire                   DSPCLK,
  input  wire                   T_RST,
  input  wire                   wrValid,
  output logic                  wrReady,
  input  wire timerPkg::regAddr_e wrAddr,
  input  wire [`TMR_CNT_W-1:0]  wrData,
  input  wire timerPkg::regAddr_e rdAddr,
  output logic [`TMR_CNT_W-1:0] rdData,
  input  wire [`TMR_CNT_W-1:0]  liveCount,
  output timerPkg::cfgMsg_t     cfg
);

  logic                  wrAccept;
  logic                  wrLoad;        // TSR or TCR, both reload a counter
  logic                  loadPreQ;
  logic                  loadCntQ;
  logic [`TMR_PRE_W-1:0] tsrQ;
  logic [`TMR_CNT_W-1:0] tcrQ;
  logic [`TMR_CNT_W-1:0] tprQ;

  assign wrAccept = wrValid && wrReady;
  assign wrLoad   = (wrAddr == timerPkg::REG_TSR) || (wrAddr == timerPkg::REG_TCR);

  // ==============================
  // Write handshake and load requests
  // ==============================
  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
    begin
      wrReady  <= 1'b1;
      loadPreQ <= 1'b0;
      loadCntQ <= 1'b0;
    end
    else
    begin
      wrReady  <= !(wrAccept && wrLoad);                      // Stall while load in flight
      loadPreQ <= wrAccept && (wrAddr == timerPkg::REG_TSR);
      loadCntQ <= wrAccept && (wrAddr == timerPkg::REG_TCR);
    end
  end

  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
    begin
      tsrQ <= '0;
      tcrQ <= '0;
      tprQ <= '0;
    end
    else if (wrAccept)
    begin
      case (wrAddr)
        timerPkg::REG_TSR: tsrQ <= wrData[`TMR_PRE_W-1:0];
        timerPkg::REG_TCR: tcrQ <= wrData;
        timerPkg::REG_TPR: tprQ <= wrData;
        default: ;                                            // Unmapped write dropped
      endcase
    end
  end

  assign cfg = '{loadPre: loadPreQ, loadCnt: loadCntQ, preVal: tsrQ, cntVal: tcrQ,
                 period: tprQ};

  // ==============================
  // Read mux
  // ==============================
  always_comb
  begin
    case (rdAddr)
      timerPkg::REG_TSR: rdData = {{`TMR_PRE_PAD{1'b0}}, tsrQ};
      timerPkg::REG_TCR: rdData = liveCount;                  // Live count, not the written TCR
      timerPkg::REG_TPR: rdData = tprQ;
      default:           rdData = '0;
    endcase
  end

  // The stall cycle is the cycle the load request is on its way to the prescaler
  aLoadStall: assert property (@(posedge DSPCLK) disable iff (T_RST)
    wrAccept && wrLoad |=> !wrReady && (cfg.loadPre || cfg.loadCnt))
    else $error("timerRegs: no stall with a load in flight after a TSR/TCR write");

endmodule

`default_nettype wire

// File: hw/timerPrescale.sv
`timescale 1ns/10ps
`default_nettype none
`include "timerUnit_defines.svh"

module timerPrescale
(
  input  wire                   DSPCLK,
  input  wire                   T_RST,
  input  wire timerPkg::cfgMsg_t cfg,
  input  wire                   timerEnable,
  input  wire                   halt,
  output timerPkg::tickMsg_t    tickOut
);

  logic [`TMR_PRE_W-1:0] preCnt;
  logic                  run;
  logic                  preZero;
  logic                  tickQ;
  logic                  loadCntQ;
  logic [`TMR_CNT_W-1:0] cntValQ;
  logic [`TMR_CNT_W-1:0] periodQ;

  assign run     = timerEnable && !halt;
  assign preZero = (preCnt == '0);

  // Prescale down-counter, one tick every TSR+1 clocks
  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
      preCnt <= '0;
    else if (cfg.loadPre)
      preCnt <= cfg.preVal;                 // New TSR restarts the prescaler
    else if (run)
    begin
      if (preZero)
        preCnt <= cfg.preVal;
      else
        preCnt <= preCnt - 1'b1;
    end
  end

  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
    begin
      tickQ    <= 1'b0;
      loadCntQ <= 1'b0;
      cntValQ  <= '0;
      periodQ  <= '0;
    end
    else
    begin
      tickQ    <= run && preZero && !cfg.loadPre;
      loadCntQ <= cfg.loadCnt;              // Kept in step with the ticks
      cntValQ  <= cfg.cntVal;
      periodQ  <= cfg.period;
    end
  end

  assign tickOut = '{tick: tickQ, loadCnt: loadCntQ, cntVal: cntValQ, period: periodQ};

  // Idle cycle gives no tick and leaves the prescaler where it was
  aNoTickIdle: assert property (@(posedge DSPCLK) disable iff (T_RST)
    !run |=> !tickOut.tick && ($past(cfg.loadPre) || preCnt == $past(preCnt)))
    else $error("timerPrescale: tick or prescale step after a disabled or halted cycle");

endmodule

`default_nettype wire

// File: hw/timerCount.sv
`timescale 1ns/10ps
`default_nettype none
`include "timerUnit_defines.svh"

module timerCount
(
  input  wire                    DSPCLK,
  input  wire                    T_RST,
  input  wire timerPkg::tickMsg_t tickIn,
  output logic [`TMR_CNT_W-1:0]  count,
  output timerPkg::expireMsg_t   expireOut
);

  logic [`TMR_CNT_W-1:0] cnt;
  logic                  cntZero;
  logic                  expireQ;

  assign cntZero = (cnt == '0);

  // ==============================
  // Count down-counter
  // ==============================
  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
    begin
      cnt     <= '0;
      expireQ <= 1'b0;
    end
    else
    begin
      expireQ <= 1'b0;                      // Strobe, one cycle only
      if (tickIn.loadCnt)
      begin
        cnt <= tickIn.cntVal;               // Host TCR write beats the tick
      end
      else if (tickIn.tick)
      begin
        if (cntZero)
        begin
          cnt     <= tickIn.period;         // Wrap to TPR
          expireQ <= 1'b1;
        end
        else
        begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  assign count     = cnt;
  assign expireOut = '{expire: expireQ};

  // The wrap value is the period carried by the tick that caused it
  aExpireReload: assert property (@(posedge DSPCLK) disable iff (T_RST)
    expireOut.expire |-> count == $past(tickIn.period))
    else $error("timerCount: expiry without a period reload");

endmodule

`default_nettype wire

// File: hw/timerIrq.sv
`timescale 1ns/10ps
`default_nettype none

module timerIrq
(
  input  wire                      DSPCLK,
  input  wire                      T_RST,
  input  wire timerPkg::expireMsg_t expireIn,
  input  wire                      irqAck,
  output logic                     timerIrq,
  output logic                     irqPending
);

  // ==============================
  // Interrupt pulse and pending flag
  // ==============================
  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
      timerIrq <= 1'b0;
    else
      timerIrq <= expireIn.expire;          // One cycle after the expiring edge
  end

  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
      irqPending <= 1'b0;
    else if (expireIn.expire)
      irqPending <= 1'b1;                   // New expiry wins over acknowledge
    else if (irqAck)
      irqPending <= 1'b0;
  end

  aIrqPulse: assert property (@(posedge DSPCLK) disable iff (T_RST)
    timerIrq |=> !timerIrq)
    else $error("timerIrq: interrupt pulse wider than one cycle");

endmodule

`default_nettype wire

// File: hw/timerTop.sv
`timescale 1ns/10ps
`default_nettype none
`include "timerUnit_defines.svh"

module timerTop
(
  input  wire                     DSPCLK,
  input  wire                     T_RST,
  input  wire                     wrValid,
  output wire                     wrReady,
  input  wire timerPkg::regAddr_e wrAddr,
  input  wire [`TMR_CNT_W-1:0]    wrData,
  input  wire timerPkg::regAddr_e rdAddr,
  output wire [`TMR_CNT_W-1:0]    rdData,
  input  wire                     timerEnable,
  input  wire                     halt,
  input  wire                     irqAck,
  output wire                     timerIrq,
  output wire                     irqPending
);

  wire timerPkg::cfgMsg_t    cfgMsg;      // Registers to prescaler
  wire timerPkg::tickMsg_t   tickMsg;     // Prescaler to counter
  wire timerPkg::expireMsg_t expireMsg;   // Counter to interrupt
  wire [`TMR_CNT_W-1:0]      liveCount;   // TCR readback

  // ==============================
  // Stage pipeline
  // ==============================
  timerRegs regStage
  (
    .DSPCLK(DSPCLK), .T_RST(T_RST),
    .wrValid(wrValid), .wrReady(wrReady), .wrAddr(wrAddr), .wrData(wrData),
    .rdAddr(rdAddr), .rdData(rdData), .liveCount(liveCount), .cfg(cfgMsg)
  );

  timerPrescale preStage
  (
    .DSPCLK(DSPCLK), .T_RST(T_RST), .cfg(cfgMsg),
    .timerEnable(timerEnable), .halt(halt), .tickOut(tickMsg)
  );

  timerCount cntStage
  (
    .DSPCLK(DSPCLK), .T_RST(T_RST), .tickIn(tickMsg),
    .count(liveCount), .expireOut(expireMsg)
  );

  timerIrq irqStage
  (
    .DSPCLK(DSPCLK), .T_RST(T_RST), .expireIn(expireMsg), .irqAck(irqAck),
    .timerIrq(timerIrq), .irqPending(irqPending)
  );

endmodule

`default_nettype wire

// File: verif/timerTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "timerUnit_defines.svh"

module timerTb;

  localparam int WAIT_LIMIT = 2000;           // Cycles allowed per wait loop

  logic                      DSPCLK = 1'b0;
  logic                      T_RST;
  logic                      wrValid;
  wire                       wrReady;
  timerPkg::regAddr_e        wrAddr;
  logic [`TMR_CNT_W-1:0]     wrData;
  timerPkg::regAddr_e        rdAddr;
  wire  [`TMR_CNT_W-1:0]     rdData;
  logic                      timerEnable;
  logic                      halt;
  logic                      irqAck;
  wire                       timerIrq;
  wire                       irqPending;
  int                        errCount = 0;
  int                        testCount = 0;
  logic [31:0]               lfsr = 32'h4b66b652;

  timerTop i_dut
  (
    .DSPCLK(DSPCLK), .T_RST(T_RST), .wrValid(wrValid), .wrReady(wrReady), .wrAddr(wrAddr),
    .wrData(wrData), .rdAddr(rdAddr), .rdData(rdData), .timerEnable(timerEnable),
    .halt(halt), .irqAck(irqAck), .timerIrq(timerIrq), .irqPending(irqPending)
  );

  always #50 DSPCLK = ~DSPCLK;                // 100 ns period

  // ==============================
  // Helpers
  // ==============================
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // x^32 + x^22 + x^2 + x + 1
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
    $display("ERROR %s: got %h expected %h", sig, got, exp);
    return 1;
  endfunction

  task automatic writeReg(input timerPkg::regAddr_e addr, input logic [`TMR_CNT_W-1:0] data);
    int waited;
    waited = 0;
    @(posedge DSPCLK);
    wrValid <= 1'b1;
    wrAddr  <= addr;
    wrData  <= data;
    @(negedge DSPCLK);
    while (!wrReady && waited < WAIT_LIMIT)
    begin
      @(negedge DSPCLK);
      waited++;
    end
    if (!wrReady)
    begin
      $display("Write to %s was never accepted, wrReady stayed low", addr.name());
      errCount++;
    end
    @(posedge DSPCLK);                        // Accept edge
    wrValid <= 1'b0;
  endtask

  task automatic readReg(input timerPkg::regAddr_e addr, output logic [`TMR_CNT_W-1:0] data);
    @(posedge DSPCLK);
    rdAddr <= addr;
    @(negedge DSPCLK);
    data = rdData;
  endtask

  task automatic waitIrq(output int cycles);
    cycles = 0;
    do
    begin
      @(negedge DSPCLK);
      cycles++;
    end
    while (!timerIrq && cycles < WAIT_LIMIT);
    if (!timerIrq)
    begin
      $display("Timed out waiting for a timerIrq pulse");
      errCount++;
    end
  endtask

  task automatic checkFrozen(input string why);
    logic [`TMR_CNT_W-1:0] held;
    repeat (3) @(posedge DSPCLK);             // Expiry in flight drains
    @(negedge DSPCLK);
    held = rdData;
    repeat (40)
    begin
      @(negedge DSPCLK);
      if (rdData !== held) errCount += mismatch({"rdData TCR ", why}, rdData, held);
      if (timerIrq !== 1'b0) errCount += mismatch({"timerIrq ", why}, timerIrq, 0);
    end
  endtask

  task automatic endTest(input string name, input int errsBefore);
    testCount++;
    $display("%-16s %s", name, (errCount == errsBefore) ? "pass" : "fail");
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic resetReadback();
    int                    errs;
    logic [`TMR_CNT_W-1:0] d;
    logic [`TMR_CNT_W-1:0] got;
    errs = errCount;
    for (int a = 0; a < 4; a++)
    begin
      readReg(timerPkg::regAddr_e'(a), got);
      if (got !== '0) errCount += mismatch("rdData after reset", got, 0);
    end
    if (wrReady !== 1'b1) errCount += mismatch("wrReady after reset", wrReady, 1);
    repeat (3)
    begin
      d = 16'(randBits(16));
      writeReg(timerPkg::REG_TSR, d);
      readReg(timerPkg::REG_TSR, got);
      if (got !== {8'h00, d[7:0]}) errCount += mismatch("rdData TSR", got, {8'h00, d[7:0]});
      d = 16'(randBits(16));
      writeReg(timerPkg::REG_TPR, d);
      readReg(timerPkg::REG_TPR, got);
      if (got !== d) errCount += mismatch("rdData TPR", got, d);
    end
    endTest("reset/readback", errs);
  endtask

  task automatic backPressure();
    int                    errs;
    int                    waited;
    logic [`TMR_CNT_W-1:0] a;
    logic [`TMR_CNT_W-1:0] b;
    logic [`TMR_CNT_W-1:0] got;
    errs   = errCount;
    waited = 0;
    a      = 16'(randBits(16));
    b      = 16'(randBits(16));
    @(posedge DSPCLK);
    wrValid <= 1'b1;
    wrAddr  <= timerPkg::REG_TCR;
    wrData  <= a;
    @(negedge DSPCLK);
    while (!wrReady && waited < WAIT_LIMIT)
    begin
      @(negedge DSPCLK);
      waited++;
    end
    if (!wrReady)
    begin
      $display("TCR write was never accepted, wrReady stayed low");
      errCount++;
    end
    @(posedge DSPCLK);                        // TCR accepted here
    wrAddr <= timerPkg::REG_TPR;              // Next write held valid through the stall
    wrData <= b;
    @(negedge DSPCLK);
    if (wrReady !== 1'b0) errCount += mismatch("wrReady after TCR write", wrReady, 0);
    @(posedge DSPCLK);
    @(negedge DSPCLK);
    if (wrReady !== 1'b1) errCount += mismatch("wrReady after stall", wrReady, 1);
    @(posedge DSPCLK);                        // TPR accepted here
    wrValid <= 1'b0;
    @(negedge DSPCLK);
    if (wrReady !== 1'b1) errCount += mismatch("wrReady after TPR write", wrReady, 1);
    readReg(timerPkg::REG_TPR, got);
    if (got !== b) errCount += mismatch("rdData TPR", got, b);
    readReg(timerPkg::REG_TCR, got);
    if (got !== a) errCount += mismatch("rdData TCR", got, a);
    endTest("back-pressure", errs);
  endtask

  task automatic irqPeriod();
    int errs;
    int p;
    int r;
    int gap;
    errs = errCount;
    @(posedge DSPCLK);
    timerEnable <= 1'b1;
    repeat (4)
    begin
      p = int'(randBits(2));
      r = 1 + int'(randBits(3));
      writeReg(timerPkg::REG_TSR, 16'(p));
      writeReg(timerPkg::REG_TPR, 16'(r));
      writeReg(timerPkg::REG_TCR, '0);
      repeat (3) waitIrq(gap);                // Last gap is the steady one
      if (gap != (r + 1) * (p + 1))
        errCount += mismatch("timerIrq period", gap, (r + 1) * (p + 1));
    end
    endTest("period", errs);
  endtask

  task automatic liveCountTrack();
    int                    errs;
    int                    r;
    int                    c;
    int                    waited;
    logic [`TMR_CNT_W-1:0] expCnt;
    logic                  pendExp;
    logic                  wrapPrev;
    errs   = errCount;
    waited = 0;
    r      = 1 + int'(randBits(3));
    c      = 2 + int'(randBits(4));
    @(posedge DSPCLK);
    timerEnable <= 1'b0;
    writeReg(timerPkg::REG_TSR, '0);
    writeReg(timerPkg::REG_TPR, 16'(r));
    writeReg(timerPkg::REG_TCR, 16'(c));
    @(posedge DSPCLK);
    irqAck <= 1'b1;
    rdAddr <= timerPkg::REG_TCR;
    @(posedge DSPCLK);
    irqAck <= 1'b0;
    @(negedge DSPCLK);
    if (rdData !== 16'(c)) errCount += mismatch("rdData TCR loaded", rdData, c);
    if (irqPending !== 1'b0) errCount += mismatch("irqPending after ack", irqPending, 0);
    @(posedge DSPCLK);
    timerEnable <= 1'b1;
    do
    begin
      @(negedge DSPCLK);
      waited++;
    end
    while (rdData === 16'(c) && waited < WAIT_LIMIT);
    if (rdData === 16'(c))
    begin
      $display("TCR never started counting after the timer was enabled");
      errCount++;
    end
    expCnt   = 16'(c - 1);
    pendExp  = 1'b0;
    wrapPrev = 1'b0;
    repeat (c + 4)
    begin
      if (rdData !== expCnt) errCount += mismatch("rdData TCR counting", rdData, expCnt);
      if (irqPending !== pendExp) errCount += mismatch("irqPending", irqPending, pendExp);
      pendExp  = pendExp | wrapPrev;          // Pending one edge after the wrap
      wrapPrev = (expCnt == '0);
      expCnt   = (expCnt == '0) ? 16'(r) : expCnt - 16'd1;
      @(negedge DSPCLK);
    end
    endTest("live count", errs);
  endtask

  task automatic haltResume();
    int errs;
    int gap;
    errs = errCount;
    @(posedge DSPCLK);
    rdAddr <= timerPkg::REG_TCR;
    halt   <= 1'b1;
    checkFrozen("halted");
    @(posedge DSPCLK);
    halt <= 1'b0;
    waitIrq(gap);
    @(posedge DSPCLK);
    timerEnable <= 1'b0;
    checkFrozen("disabled");
    @(posedge DSPCLK);
    timerEnable <= 1'b1;
    waitIrq(gap);
    endTest("halt/disable", errs);
  endtask

  task automatic pendingAck();
    int errs;
    int gap;
    errs = errCount;
    writeReg(timerPkg::REG_TPR, 16'(4 + int'(randBits(3))));
    repeat (2) waitIrq(gap);                  // Old period drains
    repeat (3)
    begin
      waitIrq(gap);
      if (irqPending !== 1'b1) errCount += mismatch("irqPending with pulse", irqPending, 1);
      @(posedge DSPCLK);
      irqAck <= 1'b1;
      @(negedge DSPCLK);
      if (timerIrq !== 1'b0) errCount += mismatch("timerIrq second cycle", timerIrq, 0);
      @(posedge DSPCLK);
      irqAck <= 1'b0;
      @(negedge DSPCLK);
      if (irqPending !== 1'b0) errCount += mismatch("irqPending after ack", irqPending, 0);
    end
    endTest("pending/ack", errs);
  endtask

  // ==============================
  // Run
  // ==============================
  initial
  begin
    #(100 * 50000);
    $display("Simulation watchdog expired before the tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    T_RST       = 1'b1;
    wrValid     = 1'b0;
    wrAddr      = timerPkg::REG_NONE;
    wrData      = '0;
    rdAddr      = timerPkg::REG_NONE;
    timerEnable = 1'b0;
    halt        = 1'b0;
    irqAck      = 1'b0;
    repeat (5) @(posedge DSPCLK);
    T_RST <= 1'b0;
    resetReadback();
    backPressure();
    irqPeriod();
    liveCountTrack();
    haltResume();
    pendingAck();
    $display("Tests run %0d, failed checks %0d", testCount, errCount);
    if (errCount == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: timerUnit.f
+incdir+include
hw/timerPkg.sv
hw/timerRegs.sv
hw/timerPrescale.sv
hw/timerCount.sv
hw/timerIrq.sv
hw/timerTop.sv
verif/timerTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the timerUnit testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module timerTb -f timerUnit.f -o timerSim
./obj_dir/timerSim | tee sim.log
if grep -qx "NO ERRORS" sim.log
then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
